// ==== list.f ====
rtl/cpu_pkg.sv
rtl/pipe_reg.sv
rtl/memory.sv
rtl/decoder.sv
rtl/hazard_unit.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/cpu_top.sv
test/tb_clock.sv
test/cpu_asserts.sv
test/cpu_tb.sv

// ==== program.hex ====
// one hex byte per line from address 00, opcode in bits 7:4,
// ra in bits 3:2, rb in bits 1:0, ldm followed by its immediate byte
90 // ldm r0
5a
94 // ldm r1
3c
21 // add r0,r1
31 // sub r0,r1
70 // out r0
41 // and r0,r1
64 // not r1,r0
54 // or r1,r0
19 // mov r2,r1
72 // out r2
70 // out r0
28 // add r2,r0 sets c
72 // out r2
94 // 0f ldm r1
c3
8c // in r3
2d // add r3,r1
73 // out r3
71 // out r1
90 // 15 ldm r0
f0
b3 // std [r0],r3
a8 // ldd r2,[r0]
72 // out r2 after load
2a // add r2,r2
72 // out r2
94 // 1c ldm r1
22
30 // sub r0,r0
c1 // jz r1 taken
70
70
70 // 22 out r0
94 // ldm r1
2b
9c // ldm r3
01
33 // sub r0,r3
d1 // jn r1 taken
70
70
94 // 2b ldm r1
34
4f // and r3,r3 keeps c
c1 // jz r1 not taken
d1 // jn r1 not taken
73 // out r3
e1 // jc r1 taken
70
70
70 // 34 out r0
2f // add r3,r3 clears c
e1 // jc r1 not taken
73 // out r3
94 // ldm r1
3a
f1 // 3a jmp r1 to itself

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    localparam int data_w    = 8;    // data and address width
    localparam int reg_idx_w = 2;    // four registers
    localparam int mem_depth = 256;  // one byte per address

    typedef logic [data_w-1:0]    word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // instruction byte is {opcode, ra, rb}
    typedef enum logic [3:0] {
        op_nop, op_mov, op_add, op_sub, op_and, op_or, op_not, op_out,
        op_in,  op_ldm, op_ldd, op_std, op_jz,  op_jn, op_jc,  op_jmp
    } opcode_e;

    typedef enum logic [2:0] {
        pass_b, add, sub, and_op, or_op, not_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu, wb_mem, wb_in  // write-back source
    } wb_sel_e;

    typedef enum logic [2:0] {
        br_none, br_jz, br_jn, br_jc, br_jmp
    } br_type_e;

    typedef struct packed {
        logic z;
        logic n;
        logic c;  // carry out on add, borrow on sub
        logic v;
    } flags_t;

    // all zero is a bubble
    typedef struct packed {
        alu_op_e  alu_op;
        br_type_e br_type;
        logic     flag_en;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     out_en;
        wb_sel_e  wb_sel;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t in_val;  // input port sampled at fetch
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t ra;
        reg_idx_t rb;
        reg_idx_t rd;
        word_t    ra_val;
        word_t    rb_val;
        word_t    imm;
        logic     use_imm;  // imm replaces rb at alu input
        word_t    in_val;
    } id_ex_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_write;
        logic     out_en;
        wb_sel_e  wb_sel;
        reg_idx_t rd;
        word_t    alu_res;     // also the data address
        word_t    store_data;
        word_t    in_val;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        logic     out_en;
        wb_sel_e  wb_sel;
        reg_idx_t rd;
        word_t    alu_res;
        word_t    mem_data;
        word_t    in_val;
    } mem_wb_t;

    localparam word_t reset_pc = '0;

endpackage

// ==== rtl/cpu_top.sv ====
module cpu_top import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t in_port,
    output word_t out_port,
    output logic  out_valid
);

    word_t      pc;
    word_t      instr_f;     // fetch port data
    logic       stall;
    logic       taken;
    logic       issue;
    if_id_t     if_d, if_q;
    id_ex_t     id_d, id_q;
    ex_mem_t    ex_d, ex_q;
    mem_wb_t    wb_d, wb_q;
    ctrl_t      id_ctrl;
    reg_idx_t   id_ra, id_rb, id_rd;
    word_t      id_imm;
    logic       id_use_imm;
    logic [1:0] id_reads;
    word_t      ra_val, rb_val;
    logic [1:0] fwd_a, fwd_b;
    word_t      ex_a;        // forwarded ra
    word_t      ex_rb_fwd;   // forwarded rb, also jump target
    word_t      ex_b;
    word_t      alu_res;
    word_t      mem_fwd;     // ex/mem result for forwarding
    word_t      data_b;
    word_t      wb_val;
    word_t      out_hold;    // last value sent out

    function automatic word_t fwd_mux(logic [1:0] sel, word_t reg_val);
        unique case (sel)
            2'd1:    return mem_fwd;
            2'd2:    return wb_val;
            default: return reg_val;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (taken) begin
            pc <= ex_rb_fwd;  // jump resolved in execute
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    memory u_mem (
        .clk     (clk),
        .addr_a  (pc),
        .data_a  (instr_f),
        .addr_b  (ex_q.alu_res),
        .we_b    (ex_q.mem_write),
        .wdata_b (ex_q.store_data),
        .data_b  (data_b)
    );

    assign if_d = '{instr: instr_f, in_val: in_port};

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (!stall),  // hold on load-use
        .flush (taken),
        .d     (if_d),
        .q     (if_q)
    );

    decoder u_dec (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (taken),
        .instr   (if_q.instr),
        .ctrl    (id_ctrl),
        .ra      (id_ra),
        .rb      (id_rb),
        .rd      (id_rd),
        .imm     (id_imm),
        .use_imm (id_use_imm),
        .reads   (id_reads),
        .issue   (issue)
    );

    register_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (wb_q.reg_write),
        .wa     (wb_q.rd),
        .wd     (wb_val),
        .ra     (id_ra),
        .rb     (id_rb),
        .ra_val (ra_val),
        .rb_val (rb_val)
    );

    hazard_unit u_hz (
        .id_ra         (id_ra),
        .id_rb         (id_rb),
        .id_reads      (id_reads),
        .ex_rd         (id_q.rd),
        .ex_mem_read   (id_q.ctrl.mem_read),
        .ex_ra         (id_q.ra),
        .ex_rb         (id_q.rb),
        .mem_rd        (ex_q.rd),
        .mem_reg_write (ex_q.reg_write),
        .wb_rd         (wb_q.rd),
        .wb_reg_write  (wb_q.reg_write),
        .stall         (stall),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    assign id_d = '{ctrl: id_ctrl, ra: id_ra, rb: id_rb, rd: id_rd,
                    ra_val: ra_val, rb_val: rb_val, imm: id_imm,
                    use_imm: id_use_imm, in_val: if_q.in_val};

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (1'b1),
        .flush (taken || stall || !issue),  // bubble in
        .d     (id_d),
        .q     (id_q)
    );

    assign mem_fwd   = (ex_q.wb_sel == wb_in) ? ex_q.in_val : ex_q.alu_res;
    assign ex_a      = fwd_mux(fwd_a, id_q.ra_val);
    assign ex_rb_fwd = fwd_mux(fwd_b, id_q.rb_val);
    assign ex_b      = id_q.use_imm ? id_q.imm : ex_rb_fwd;

    execute_unit u_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (id_q.ctrl),
        .a       (ex_a),
        .b       (ex_b),
        .alu_res (alu_res),
        .taken   (taken)
    );

    // std data travels on the ra path
    assign ex_d = '{reg_write: id_q.ctrl.reg_write, mem_write: id_q.ctrl.mem_write,
                    out_en: id_q.ctrl.out_en, wb_sel: id_q.ctrl.wb_sel, rd: id_q.rd,
                    alu_res: alu_res, store_data: ex_a, in_val: id_q.in_val};

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (1'b1),
        .flush (1'b0),
        .d     (ex_d),
        .q     (ex_q)
    );

    assign wb_d = '{reg_write: ex_q.reg_write, out_en: ex_q.out_en, wb_sel: ex_q.wb_sel,
                    rd: ex_q.rd, alu_res: ex_q.alu_res, mem_data: data_b,
                    in_val: ex_q.in_val};

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (1'b1),
        .flush (1'b0),
        .d     (wb_d),
        .q     (wb_q)
    );

    always_comb begin
        unique case (wb_q.wb_sel)
            wb_mem:  wb_val = wb_q.mem_data;
            wb_in:   wb_val = wb_q.in_val;
            default: wb_val = wb_q.alu_res;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_hold <= '0;
        end else if (wb_q.out_en) begin
            out_hold <= wb_q.alu_res;
        end
    end

    assign out_valid = wb_q.out_en;  // one cycle per OUT
    assign out_port  = wb_q.out_en ? wb_q.alu_res : out_hold;

endmodule

// ==== rtl/decoder.sv ====
module decoder import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  word_t      instr,
    output ctrl_t      ctrl,
    output reg_idx_t   ra,
    output reg_idx_t   rb,
    output reg_idx_t   rd,
    output word_t      imm,
    output logic       use_imm,
    output logic [1:0] reads,  // bit 0 ra read, bit 1 rb read
    output logic       issue
);

    opcode_e  op;
    logic     ldm_pend;  // next IF/ID byte is the immediate
    reg_idx_t ldm_rd;    // destination saved from first byte

    assign op  = opcode_e'(instr[7:4]);
    assign imm = instr;  // only meaningful while ldm_pend

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ldm_pend <= 1'b0;
        end else if (flush) begin
            ldm_pend <= 1'b0;  // squashed ldm never completes
        end else begin
            ldm_pend <= !ldm_pend && (op == op_ldm);
        end
    end

    always_ff @(posedge clk) begin
        if (!ldm_pend) begin
            ldm_rd <= instr[3:2];
        end
    end

    always_comb begin
        ctrl    = '0;
        ra      = instr[3:2];
        rb      = instr[1:0];
        rd      = instr[3:2];
        use_imm = 1'b0;
        reads   = 2'b00;
        issue   = 1'b1;
        if (ldm_pend) begin  // second byte, issue the load-immediate
            ctrl.alu_op    = pass_b;
            ctrl.reg_write = 1'b1;
            use_imm        = 1'b1;
            rd             = ldm_rd;
        end else begin
            unique case (op)
                op_nop: begin
                end
                op_mov: begin
                    ctrl.alu_op    = pass_b;
                    ctrl.reg_write = 1'b1;
                    reads          = 2'b10;
                end
                op_add, op_sub, op_and, op_or: begin
                    ctrl.alu_op    = (op == op_add) ? add :
                                     (op == op_sub) ? sub :
                                     (op == op_and) ? and_op : or_op;
                    ctrl.flag_en   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    reads          = 2'b11;
                end
                op_not: begin
                    ctrl.alu_op    = not_b;
                    ctrl.flag_en   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    reads          = 2'b10;
                end
                op_out: begin
                    ctrl.alu_op = pass_b;  // rb rides alu_res to the port
                    ctrl.out_en = 1'b1;
                    reads       = 2'b10;
                end
                op_in: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_in;
                end
                op_ldm: begin
                    issue = 1'b0;  // wait one cycle for the immediate
                end
                op_ldd: begin
                    ctrl.alu_op    = pass_b;  // address from rb
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_mem;
                    reads          = 2'b10;
                end
                op_std: begin
                    // swapped so the address goes through pass_b
                    ctrl.alu_op    = pass_b;
                    ctrl.mem_write = 1'b1;
                    ra             = instr[1:0];  // store data
                    rb             = instr[3:2];  // address
                    reads          = 2'b11;
                end
                op_jz, op_jn, op_jc, op_jmp: begin
                    ctrl.br_type = (op == op_jz) ? br_jz :
                                   (op == op_jn) ? br_jn :
                                   (op == op_jc) ? br_jc : br_jmp;
                    reads        = 2'b10;  // target in rb
                end
            endcase
        end
    end

endmodule

// ==== rtl/execute_unit.sv ====
module execute_unit import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  ctrl_t ctrl,
    input  word_t a,
    input  word_t b,
    output word_t alu_res,
    output logic  taken
);

    logic [data_w:0] sum_add;  // carry in top bit
    logic [data_w:0] sum_sub;  // borrow in top bit
    flags_t          alu_flags;
    flags_t          ccr;      // condition code register
    logic            arith;    // add/sub write c and v too

    assign sum_add = {1'b0, a} + {1'b0, b};
    assign sum_sub = {1'b0, a} - {1'b0, b};
    assign arith   = (ctrl.alu_op == add) || (ctrl.alu_op == sub);

    always_comb begin
        alu_flags = '0;
        unique case (ctrl.alu_op)
            add: begin
                alu_res     = sum_add[data_w-1:0];
                alu_flags.c = sum_add[data_w];
                alu_flags.v = (a[data_w-1] == b[data_w-1]) &&
                              (alu_res[data_w-1] != a[data_w-1]);
            end
            sub: begin
                alu_res     = sum_sub[data_w-1:0];
                alu_flags.c = sum_sub[data_w];
                alu_flags.v = (a[data_w-1] != b[data_w-1]) &&
                              (alu_res[data_w-1] != a[data_w-1]);
            end
            and_op:  alu_res = a & b;
            or_op:   alu_res = a | b;
            not_b:   alu_res = ~b;
            default: alu_res = b;  // pass_b
        endcase
        alu_flags.z = (alu_res == '0);
        alu_flags.n = alu_res[data_w-1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ccr <= '0;
        end else if (ctrl.flag_en) begin
            ccr.z <= alu_flags.z;
            ccr.n <= alu_flags.n;
            if (arith) begin  // logic ops keep c and v
                ccr.c <= alu_flags.c;
                ccr.v <= alu_flags.v;
            end
        end
    end

    // branches look at committed flags only
    always_comb begin
        unique case (ctrl.br_type)
            br_jz:   taken = ccr.z;
            br_jn:   taken = ccr.n;
            br_jc:   taken = ccr.c;
            br_jmp:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

endmodule

// ==== rtl/hazard_unit.sv ====
module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t   id_ra,
    input  reg_idx_t   id_rb,
    input  logic [1:0] id_reads,
    input  reg_idx_t   ex_rd,
    input  logic       ex_mem_read,
    input  reg_idx_t   ex_ra,
    input  reg_idx_t   ex_rb,
    input  reg_idx_t   mem_rd,
    input  logic       mem_reg_write,
    input  reg_idx_t   wb_rd,
    input  logic       wb_reg_write,
    output logic       stall,
    output logic [1:0] fwd_a,  // 0 reg, 1 ex/mem, 2 write-back
    output logic [1:0] fwd_b
);

    // load data exists only after mem, so the consumer waits one cycle
    assign stall = ex_mem_read &&
                   ((id_reads[0] && (id_ra == ex_rd)) ||
                    (id_reads[1] && (id_rb == ex_rd)));

    always_comb begin
        fwd_a = 2'd0;
        if (mem_reg_write && (mem_rd == ex_ra)) begin
            fwd_a = 2'd1;  // youngest result first
        end else if (wb_reg_write && (wb_rd == ex_ra)) begin
            fwd_a = 2'd2;
        end
    end

    always_comb begin
        fwd_b = 2'd0;
        if (mem_reg_write && (mem_rd == ex_rb)) begin
            fwd_b = 2'd1;
        end else if (wb_reg_write && (wb_rd == ex_rb)) begin
            fwd_b = 2'd2;
        end
    end

endmodule

// ==== rtl/memory.sv ====
module memory import cpu_pkg::*; (
    input  logic  clk,
    input  word_t addr_a,
    output word_t data_a,
    input  word_t addr_b,
    input  logic  we_b,
    input  word_t wdata_b,
    output word_t data_b
);

    word_t mem [mem_depth];  // program and data share one array

    initial begin
        $readmemh("program.hex", mem);
    end

    assign data_a = mem[addr_a];  // fetch port, async read
    assign data_b = mem[addr_b];  // load port, async read

    always_ff @(posedge clk) begin
        if (we_b) begin
            mem[addr_b] <= wdata_b;  // store commits at edge
        end
    end

endmodule

// ==== rtl/pipe_reg.sv ====
module pipe_reg #(
    parameter type payload_t = logic  // stage struct
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;  // bubble out of reset
        end else if (flush) begin
            q <= '0;  // flush wins over enable
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// ==== rtl/register_file.sv ====
module register_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  reg_idx_t wa,
    input  word_t    wd,
    input  reg_idx_t ra,
    input  reg_idx_t rb,
    output word_t    ra_val,
    output word_t    rb_val
);

    word_t regs [2**reg_idx_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_idx_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // write-back value seen by decode in the same cycle
    assign ra_val = (we && (wa == ra)) ? wd : regs[ra];
    assign rb_val = (we && (wa == rb)) ? wd : regs[rb];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f list.f -o cpu_sim \
    && ./obj_dir/cpu_sim +verilator+error+limit+1000 | tee sim.log
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== test/cpu_asserts.sv ====
module cpu_asserts import cpu_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  out_valid,
    input logic  stall,
    input word_t pc
);

    int unsigned err_cnt = 0;  // checked by cpu_tb at the end

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            $error("out_valid high while rst_n is low");
            err_cnt++;
        end

    valid_known: assert property (@(posedge clk) !$isunknown(out_valid))
        else begin
            $error("out_valid is unknown");
            err_cnt++;
        end

    // load-use stall freezes fetch
    pc_held: assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(pc))
        else begin
            $error("pc moved during a stall");
            err_cnt++;
        end

    pc_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> (pc == reset_pc))
        else begin
            $error("pc not at the reset address after reset");
            err_cnt++;
        end

endmodule

bind cpu_top cpu_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .stall     (stall),
    .pc        (pc)
);

// ==== test/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*; ();

    localparam int n_runs    = 4;
    localparam int n_outs    = 12;    // OUTs before the self-jump
    localparam int drain_cyc = 16;    // window for stray OUTs
    localparam int max_steps = 2000;  // stops a runaway reference

    logic        clk;
    logic        rst_n;
    word_t       in_port;
    word_t       out_port;
    logic        out_valid;

    word_t       prog [mem_depth];  // program image for the reference
    word_t       exp_q [$];         // expected OUT values of this run
    logic [31:0] seed;
    int          run;
    int          got_cnt;     // OUTs seen this run
    int          extra_cnt;   // OUTs past the expected ones
    int          bad_in_grp;  // wrong values in the open section
    int          hold_bad;    // idle cycles where out_port lost the last OUT
    int          pass_cnt;
    int          fail_cnt;
    bit          timed_out;

    tb_clock u_clk (
        .clk (clk)
    );

    cpu_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_port   (in_port),
        .out_port  (out_port),
        .out_valid (out_valid)
    );

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // program sections by OUT index
    function automatic string section_name(int idx);
        if (idx < 4) begin
            return "alu";
        end else if (idx < 6) begin
            return "ldm_in";
        end else if (idx < 8) begin
            return "memory";
        end
        return "branch";
    endfunction

    function automatic bit section_end(int cnt);
        return (cnt == 4) || (cnt == 6) || (cnt == 8) || (cnt == 12);
    endfunction

    // instruction-set model, fills exp_q and returns instructions executed
    function automatic int run_reference(word_t in_val);
        word_t           mem [mem_depth];
        word_t           r [4];
        flags_t          fl;
        word_t           pc;
        word_t           a;
        word_t           b;
        word_t           res;
        logic [data_w:0] wide;
        opcode_e         op;
        reg_idx_t        ia;
        reg_idx_t        ib;
        int              steps;
        mem   = prog;  // stores stay local to this run
        r     = '{default: '0};
        fl    = '0;
        pc    = reset_pc;
        steps = 0;
        exp_q.delete();
        while ((exp_q.size() < n_outs) && (steps < max_steps)) begin
            op = opcode_e'(mem[pc][7:4]);
            ia = mem[pc][3:2];
            ib = mem[pc][1:0];
            a  = r[ia];
            b  = r[ib];
            pc = pc + 8'd1;
            steps++;
            case (op)
                op_mov: r[ia] = b;
                op_add: begin
                    wide  = {1'b0, a} + {1'b0, b};
                    res   = wide[7:0];
                    fl.c  = wide[8];  // carry out
                    fl.v  = (a[7] == b[7]) && (res[7] != a[7]);
                    fl.z  = (res == 8'h00);
                    fl.n  = res[7];
                    r[ia] = res;
                end
                op_sub: begin
                    res   = a - b;
                    fl.c  = (a < b);  // borrow
                    fl.v  = (a[7] != b[7]) && (res[7] != a[7]);
                    fl.z  = (res == 8'h00);
                    fl.n  = res[7];
                    r[ia] = res;
                end
                op_and, op_or, op_not: begin
                    res   = (op == op_and) ? (a & b) : (op == op_or) ? (a | b) : ~b;
                    fl.z  = (res == 8'h00);  // c and v untouched
                    fl.n  = res[7];
                    r[ia] = res;
                end
                op_out: exp_q.push_back(b);
                op_in:  r[ia] = in_val;
                op_ldm: begin
                    r[ia] = mem[pc];  // next byte is the value
                    pc    = pc + 8'd1;
                end
                op_ldd: r[ia] = mem[b];
                op_std: mem[a] = b;
                op_jz:  if (fl.z) pc = b;
                op_jn:  if (fl.n) pc = b;
                op_jc:  if (fl.c) pc = b;
                op_jmp: pc = b;
                default: ;  // nop
            endcase
        end
        return steps;
    endfunction

    // output checker, sampled on the falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (got_cnt >= exp_q.size()) begin
                $display("run %0d: an extra OUT of 0x%02h came after the last expected one",
                         run, out_port);
                extra_cnt++;
            end else begin
                if (out_port !== exp_q[got_cnt]) begin
                    $display("[ERROR] run%0d_%s: expected 0x%02h, actual 0x%02h",
                             run, section_name(got_cnt), exp_q[got_cnt], out_port);
                    bad_in_grp++;
                end
                got_cnt++;
                if (section_end(got_cnt)) begin
                    if (bad_in_grp == 0) begin
                        $display("run%0d_%s: pass", run, section_name(got_cnt - 1));
                        pass_cnt++;
                    end else begin
                        $display("run%0d_%s: fail, %0d wrong values",
                                 run, section_name(got_cnt - 1), bad_in_grp);
                        fail_cnt++;
                    end
                    bad_in_grp = 0;
                end
            end
        end else if (rst_n && (got_cnt > 0) && (extra_cnt == 0)) begin
            // between strobes the port keeps the last OUT
            if (out_port !== exp_q[got_cnt - 1]) begin
                $display("[ERROR] run%0d_port_hold: expected 0x%02h, actual 0x%02h",
                         run, exp_q[got_cnt - 1], out_port);
                hold_bad++;
            end
        end
    end

    initial begin
        int steps;
        int limit;
        int cycles;
        rst_n      = 1'b0;
        in_port    = '0;
        seed       = 32'h58ee;
        run        = 0;
        got_cnt    = 0;
        extra_cnt  = 0;
        bad_in_grp = 0;
        hold_bad   = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        timed_out  = 1'b0;
        $readmemh("program.hex", prog);
        for (int i = 0; (i < n_runs) && !timed_out; i++) begin
            seed = lcg_next(seed);
            @(posedge clk);
            #1;
            rst_n      = 1'b0;
            in_port    = seed[23:16];  // held for the whole run
            run        = i;
            got_cnt    = 0;
            extra_cnt  = 0;
            bad_in_grp = 0;
            hold_bad   = 0;
            steps      = run_reference(in_port);
            limit      = 4 * steps + 20;
            repeat (2) @(posedge clk);
            #1;
            rst_n  = 1'b1;
            cycles = 0;
            while ((got_cnt < n_outs) && (cycles < limit)) begin
                @(posedge clk);
                cycles++;
            end
            if (got_cnt < n_outs) begin
                $display("run %0d timed out after %0d cycles, %0d of %0d OUT values missing",
                         i, cycles, n_outs - got_cnt, n_outs);
                fail_cnt++;
                timed_out = 1'b1;
            end else begin
                repeat (drain_cyc) @(posedge clk);  // self-jump must stay silent
                if (extra_cnt == 0) begin
                    $display("run%0d_out_count: pass", i);
                    pass_cnt++;
                end else begin
                    $display("run%0d_out_count: fail, %0d OUT values instead of %0d",
                             i, n_outs + extra_cnt, n_outs);
                    fail_cnt++;
                end
                if (hold_bad == 0) begin
                    $display("run%0d_port_hold: pass", i);
                    pass_cnt++;
                end else begin
                    $display("run%0d_port_hold: fail, %0d cycles with a wrong value",
                             i, hold_bad);
                    fail_cnt++;
                end
            end
        end
        if (DUT.u_asserts.err_cnt != 0) begin
            $display("the bound assertions failed %0d times", DUT.u_asserts.err_cnt);
            fail_cnt++;
        end
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
module tb_clock (
    output logic clk
);

    localparam int half_period = 4;  // 8 unit period

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule
